/* Makefile */
# Verilator build and run for the machine CSR subsystem

FILE_LIST := machine_csr_top.f

.PHONY: all build run lint clean

all: run
	@if grep -q "SIMULATION FAILED" sim.log; then \
		echo "Failure found in sim.log"; exit 1; \
	fi
	@grep -q "SIMULATION PASSED" sim.log || (echo "No pass line in sim.log"; exit 1)

build:
	verilator --binary --timing -sv -f $(FILE_LIST) --top-module machine_csr_tb \
		-Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee sim.log

lint:
	verilator --lint-only -sv -f $(FILE_LIST) --top-module machine_csr_top

clean:
	rm -rf obj_dir sim.log

/* machine_csr_top.f */
+incdir+src
src/csr_pkg.sv
src/csr_request_stage.sv
src/csr_file.sv
src/trap_controller.sv
src/machine_csr_top.sv
verification/csr_checker.sv
verification/machine_csr_tb.sv

/* src/csr_consts.svh */
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Machine information CSRs
`define CSR_MARCHID        12'hF12
`define CSR_MIMPID         12'hF13

// Machine trap setup
`define CSR_MSTATUS        12'h300
`define CSR_MISA           12'h301
`define CSR_MIE            12'h304
`define CSR_MTVEC          12'h305
`define CSR_MSTATUSH       12'h310

// Machine trap handling
`define CSR_MSCRATCH       12'h340
`define CSR_MEPC           12'h341
`define CSR_MCAUSE         12'h342
`define CSR_MTVAL          12'h343
`define CSR_MIP            12'h344

// Identification words, read only
`define MISA_VALUE         32'h4000_0100   // RV32I, no extensions
`define MARCHID_VALUE      32'h0000_0018
`define MIMPID_VALUE       32'h0000_0006

// Writable bits of mie: fast lines, MEIE, MTIE, MSIE
`define MIE_WRITE_MASK     32'hFFFF_0888

// Interrupt cause codes
`define CAUSE_SOFTWARE     5'd3
`define CAUSE_TIMER        5'd7
`define CAUSE_EXTERNAL     5'd11
`define CAUSE_FAST_BASE    5'd16

`endif

/* src/csr_file.sv */
`timescale 1ns/100ps
`include "csr_consts.svh"

module csr_file (
    input  logic               clk,
    input  logic               reset,
    input  csr_pkg::csr_req_t  req,
    input  csr_pkg::trap_cmd_t trap,
    input  csr_pkg::word_t     pending,
    input  logic               mret,
    output logic               csr_rd_valid,
    output csr_pkg::word_t     csr_rd_data,
    output logic               mstatus_mie,
    output csr_pkg::word_t     mie_bits,
    output csr_pkg::word_t     mtvec
);

    // mstatus state, only MIE and MPIE are stored
    logic           status_mie;
    logic           status_mpie;
    csr_pkg::word_t mstatus_value;

    csr_pkg::word_t mie_reg;
    csr_pkg::word_t mtvec_reg;
    csr_pkg::word_t mscratch_reg;
    csr_pkg::word_t mepc_reg;
    csr_pkg::word_t mcause_reg;
    csr_pkg::word_t mtval_reg;

    csr_pkg::word_t old_value;    // Value returned to rd
    csr_pkg::word_t new_value;    // Result of the read-modify-write
    logic           write_en;

    // MPP reads as machine mode
    assign mstatus_value = {19'd0, 2'b11, 3'd0, status_mpie, 3'd0, status_mie, 3'd0};

    always_comb begin
        case (req.addr)
            `CSR_MSTATUS:  old_value = mstatus_value;
            `CSR_MSTATUSH: old_value = '0;
            `CSR_MISA:     old_value = `MISA_VALUE;
            `CSR_MARCHID:  old_value = `MARCHID_VALUE;
            `CSR_MIMPID:   old_value = `MIMPID_VALUE;
            `CSR_MIE:      old_value = mie_reg;
            `CSR_MTVEC:    old_value = mtvec_reg;
            `CSR_MSCRATCH: old_value = mscratch_reg;
            `CSR_MEPC:     old_value = mepc_reg;
            `CSR_MCAUSE:   old_value = mcause_reg;
            `CSR_MTVAL:    old_value = mtval_reg;
            `CSR_MIP:      old_value = pending;
            default:       old_value = '0;
        endcase
    end

    always_comb begin
        case (req.funct[1:0])
            2'b01:   new_value = req.operand;                // CSRRW
            2'b10:   new_value = old_value | req.operand;    // CSRRS
            2'b11:   new_value = old_value & ~req.operand;   // CSRRC
            default: new_value = old_value;
        endcase
    end

    // funct low bits of zero mean no write at all
    assign write_en = req.valid && (req.funct[1:0] != 2'b00);

    always_ff @(posedge clk) begin
        if (reset) begin
            status_mie   <= 1'b0;
            status_mpie  <= 1'b1;
            mie_reg      <= '0;
            mtvec_reg    <= '0;
            mscratch_reg <= '0;
            mepc_reg     <= '0;
            mcause_reg   <= '0;
            mtval_reg    <= '0;
        end else begin
            if (mret) begin
                status_mie  <= status_mpie;
                status_mpie <= 1'b1;
            end

            // Trap entry, never in the same cycle as a request or mret
            if (trap.take) begin
                mepc_reg    <= {trap.pc[31:2], 2'b00};
                mcause_reg  <= {1'b1, 26'd0, trap.code};
                status_mpie <= status_mie;
                status_mie  <= 1'b0;
            end

            // Software write lands last so it wins
            if (write_en) begin
                case (req.addr)
                    `CSR_MSTATUS: begin
                        status_mie  <= new_value[3];
                        status_mpie <= new_value[7];
                    end
                    `CSR_MIE:      mie_reg      <= new_value & `MIE_WRITE_MASK;
                    `CSR_MTVEC:    mtvec_reg    <= {new_value[31:2], 1'b0, new_value[0]};
                    `CSR_MSCRATCH: mscratch_reg <= new_value;
                    `CSR_MEPC:     mepc_reg     <= {new_value[31:2], 2'b00};
                    `CSR_MCAUSE:   mcause_reg   <= new_value;
                    `CSR_MTVAL:    mtval_reg    <= new_value;
                    default: begin
                        // Read-only or unknown address, ignored
                    end
                endcase
            end
        end
    end

    // Old value goes out one edge after the request
    always_ff @(posedge clk) begin
        if (reset) begin
            csr_rd_valid <= 1'b0;
        end else begin
            csr_rd_valid <= req.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            csr_rd_data <= old_value;
        end
    end

    // Enables for the trap decision
    assign mstatus_mie = status_mie;
    assign mie_bits    = mie_reg;
    assign mtvec       = mtvec_reg;

endmodule

/* src/csr_pkg.sv */
package csr_pkg;

    // Data and address widths
    typedef logic [31:0] word_t;
    typedef logic [11:0] csr_addr_t;

    // funct3 of a CSR instruction
    // Bit 2 picks the immediate form, bits 1:0 pick write/set/clear
    typedef logic [2:0] csr_funct_t;

    // Platform fast interrupt lines
    typedef logic [15:0] irq_fast_t;

    // Low bits of mcause for an interrupt
    typedef logic [4:0] cause_code_t;

    // Request held in stage 2, with the operand already selected
    typedef struct packed {
        logic       valid;
        csr_funct_t funct;
        csr_addr_t  addr;
        word_t      operand;   // rs1 data or zero-extended immediate
    } csr_req_t;

    // Trap decision handed to the register file
    typedef struct packed {
        logic        take;     // High in the cycle the trap is taken
        cause_code_t code;
        word_t       pc;       // pc to save into mepc
        word_t       target;   // Handler address from mtvec
    } trap_cmd_t;

endpackage

/* src/csr_request_stage.sv */
`timescale 1ns/100ps

module csr_request_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                csr_valid,
    input  csr_pkg::csr_funct_t csr_funct,
    input  csr_pkg::csr_addr_t  csr_addr,
    input  csr_pkg::word_t      csr_rs1_data,
    input  logic [4:0]          csr_imm,
    output csr_pkg::csr_req_t   req
);

    csr_pkg::word_t operand;
    logic           req_valid;
    csr_pkg::csr_funct_t req_funct;
    csr_pkg::csr_addr_t  req_addr;
    csr_pkg::word_t      req_operand;

    // Immediate forms take the zero-extended uimm field
    always_comb begin
        if (csr_funct[2]) begin
            operand = {27'd0, csr_imm};
        end else begin
            operand = csr_rs1_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= csr_valid;
        end
    end

    // Payload only moves with a new request
    always_ff @(posedge clk) begin
        if (csr_valid) begin
            req_funct   <= csr_funct;
            req_addr    <= csr_addr;
            req_operand <= operand;
        end
    end

    always_comb begin
        req.valid   = req_valid;
        req.funct   = req_funct;
        req.addr    = req_addr;
        req.operand = req_operand;
    end

endmodule

/* src/machine_csr_top.sv */
`timescale 1ns/100ps

module machine_csr_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                csr_valid,
    input  csr_pkg::csr_funct_t csr_funct,
    input  csr_pkg::csr_addr_t  csr_addr,
    input  csr_pkg::word_t      csr_rs1_data,
    input  logic [4:0]          csr_imm,
    input  logic                irq_external,
    input  logic                irq_timer,
    input  logic                irq_software,
    input  csr_pkg::irq_fast_t  irq_fast,
    input  csr_pkg::word_t      pc_value,
    input  logic                mret,
    output logic                csr_rd_valid,
    output csr_pkg::word_t      csr_rd_data,
    output logic                trap_taken,
    output csr_pkg::word_t      trap_pc
);

    csr_pkg::csr_req_t  req;
    csr_pkg::trap_cmd_t trap;
    csr_pkg::word_t     pending;
    csr_pkg::word_t     mie_bits;
    csr_pkg::word_t     mtvec;
    logic               mstatus_mie;

    csr_request_stage csr_request_stage_inst (
        .clk          (clk),
        .reset        (reset),
        .csr_valid    (csr_valid),
        .csr_funct    (csr_funct),
        .csr_addr     (csr_addr),
        .csr_rs1_data (csr_rs1_data),
        .csr_imm      (csr_imm),
        .req          (req)
    );

    csr_file csr_file_inst (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .trap         (trap),
        .pending      (pending),
        .mret         (mret),
        .csr_rd_valid (csr_rd_valid),
        .csr_rd_data  (csr_rd_data),
        .mstatus_mie  (mstatus_mie),
        .mie_bits     (mie_bits),
        .mtvec        (mtvec)
    );

    trap_controller trap_controller_inst (
        .clk          (clk),
        .reset        (reset),
        .irq_external (irq_external),
        .irq_timer    (irq_timer),
        .irq_software (irq_software),
        .irq_fast     (irq_fast),
        .mstatus_mie  (mstatus_mie),
        .mie_bits     (mie_bits),
        .mtvec        (mtvec),
        .req          (req),
        .mret         (mret),
        .pc_value     (pc_value),
        .pending      (pending),
        .trap         (trap)
    );

    // Jump request to the core, one cycle wide
    always_ff @(posedge clk) begin
        if (reset) begin
            trap_taken <= 1'b0;
        end else begin
            trap_taken <= trap.take;
        end
    end

    always_ff @(posedge clk) begin
        if (trap.take) begin
            trap_pc <= trap.target;
        end
    end

endmodule

/* src/trap_controller.sv */
`timescale 1ns/100ps
`include "csr_consts.svh"

module trap_controller (
    input  logic                clk,
    input  logic                reset,
    input  logic                irq_external,
    input  logic                irq_timer,
    input  logic                irq_software,
    input  csr_pkg::irq_fast_t  irq_fast,
    input  logic                mstatus_mie,
    input  csr_pkg::word_t      mie_bits,
    input  csr_pkg::word_t      mtvec,
    input  csr_pkg::csr_req_t   req,
    input  logic                mret,
    input  csr_pkg::word_t      pc_value,
    output csr_pkg::word_t      pending,
    output csr_pkg::trap_cmd_t  trap
);

    csr_pkg::word_t      pending_reg;
    csr_pkg::word_t      enabled;       // Pending and enabled in mie
    csr_pkg::cause_code_t code;
    logic                found;
    csr_pkg::word_t      base;

    // Lines land in their mip bit positions one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            pending_reg <= '0;
        end else begin
            pending_reg <= {irq_fast, 4'd0, irq_external, 3'd0,
                            irq_timer, 3'd0, irq_software, 3'd0};
        end
    end

    assign pending = pending_reg;
    assign enabled = pending_reg & mie_bits;

    // Fixed priority: external, software, timer, then fast 0 upward
    always_comb begin
        found = 1'b1;
        code  = `CAUSE_EXTERNAL;
        if (enabled[11]) begin
            code = `CAUSE_EXTERNAL;
        end else if (enabled[3]) begin
            code = `CAUSE_SOFTWARE;
        end else if (enabled[7]) begin
            code = `CAUSE_TIMER;
        end else begin
            found = 1'b0;
            for (int i = 0; i < 16; i++) begin
                if (!found && enabled[16 + i]) begin
                    code  = csr_pkg::cause_code_t'(`CAUSE_FAST_BASE + i);
                    found = 1'b1;
                end
            end
        end
    end

    assign base = {mtvec[31:2], 2'b00};

    always_comb begin
        // A request in stage 2 or an mret defers the trap
        trap.take = mstatus_mie && found && !req.valid && !mret;
        trap.code = code;
        trap.pc   = pc_value;
        if (mtvec[0]) begin
            trap.target = base + {25'd0, code, 2'b00};   // Vectored
        end else begin
            trap.target = base;
        end
    end

endmodule

/* verification/csr_checker.sv */
`timescale 1ns/100ps
`include "csr_consts.svh"

module csr_checker (
    input  logic                clk,
    input  logic                reset,
    input  logic                csr_valid,
    input  csr_pkg::csr_funct_t csr_funct,
    input  csr_pkg::csr_addr_t  csr_addr,
    input  csr_pkg::word_t      csr_rs1_data,
    input  logic [4:0]          csr_imm,
    input  logic                irq_external,
    input  logic                irq_timer,
    input  logic                irq_software,
    input  csr_pkg::irq_fast_t  irq_fast,
    input  csr_pkg::word_t      pc_value,
    input  logic                mret,
    input  logic                csr_rd_valid,
    input  csr_pkg::word_t      csr_rd_data,
    input  logic                trap_taken,
    input  csr_pkg::word_t      trap_pc,
    output int                  error_count,
    output int                  check_count
);

    // Model of stage 2 and the machine CSRs
    csr_pkg::csr_req_t m_req;
    logic           m_mie;
    logic           m_mpie;
    csr_pkg::word_t m_mie_reg, m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval, m_pending;
    csr_pkg::word_t old_val, new_val, enabled, target;
    logic           take, found;
    csr_pkg::cause_code_t code;

    logic           exp_rd_valid = 1'b0;
    csr_pkg::word_t exp_rd_data;
    logic           exp_trap = 1'b0;
    csr_pkg::word_t exp_trap_pc;

    initial begin
        error_count = 0;
        check_count = 0;
    end

    function automatic csr_pkg::word_t model_read(input csr_pkg::csr_addr_t addr);
        case (addr)
            `CSR_MSTATUS:  return {19'd0, 2'b11, 3'd0, m_mpie, 3'd0, m_mie, 3'd0};
            `CSR_MISA:     return `MISA_VALUE;
            `CSR_MARCHID:  return `MARCHID_VALUE;
            `CSR_MIMPID:   return `MIMPID_VALUE;
            `CSR_MIE:      return m_mie_reg;
            `CSR_MTVEC:    return m_mtvec;
            `CSR_MSCRATCH: return m_mscratch;
            `CSR_MEPC:     return m_mepc;
            `CSR_MCAUSE:   return m_mcause;
            `CSR_MTVAL:    return m_mtval;
            `CSR_MIP:      return m_pending;
            default:       return 32'd0;
        endcase
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            m_req.valid = 1'b0;
            {m_mie, m_mpie} = 2'b01;
            {m_mie_reg, m_mtvec, m_mscratch, m_mepc} = '0;
            {m_mcause, m_mtval, m_pending} = '0;
            exp_rd_valid = 1'b0;
            exp_trap = 1'b0;
        end else begin
            old_val = model_read(m_req.addr);
            case (m_req.funct[1:0])
                2'b01:   new_val = m_req.operand;
                2'b10:   new_val = old_val | m_req.operand;
                2'b11:   new_val = old_val & ~m_req.operand;
                default: new_val = old_val;
            endcase

            // Priority external, software, timer, fast 0..15
            enabled = m_pending & m_mie_reg;
            found = 1'b1;
            if (enabled[11]) code = 5'd11;
            else if (enabled[3]) code = 5'd3;
            else if (enabled[7]) code = 5'd7;
            else begin
                found = 1'b0;
                code = 5'd0;
                for (int i = 31; i >= 16; i--) begin
                    if (enabled[i]) begin
                        code = 5'(i);
                        found = 1'b1;
                    end
                end
            end
            take = m_mie && found && !m_req.valid && !mret;
            target = {m_mtvec[31:2], 2'b00} + (m_mtvec[0] ? {25'd0, code, 2'b00} : 32'd0);

            exp_rd_valid = m_req.valid;
            if (m_req.valid) exp_rd_data = old_val;
            exp_trap = take;
            if (take) exp_trap_pc = target;

            if (mret) begin
                m_mie = m_mpie;
                m_mpie = 1'b1;
            end
            if (take) begin
                m_mepc = {pc_value[31:2], 2'b00};
                m_mcause = {1'b1, 26'd0, code};
                m_mpie = m_mie;
                m_mie = 1'b0;
            end
            if (m_req.valid && m_req.funct[1:0] != 2'b00) begin
                case (m_req.addr)
                    `CSR_MSTATUS: begin
                        m_mie = new_val[3];
                        m_mpie = new_val[7];
                    end
                    `CSR_MIE:      m_mie_reg = new_val & `MIE_WRITE_MASK;
                    `CSR_MTVEC:    m_mtvec = {new_val[31:2], 1'b0, new_val[0]};
                    `CSR_MSCRATCH: m_mscratch = new_val;
                    `CSR_MEPC:     m_mepc = {new_val[31:2], 2'b00};
                    `CSR_MCAUSE:   m_mcause = new_val;
                    `CSR_MTVAL:    m_mtval = new_val;
                    default: ;
                endcase
            end

            m_pending = {irq_fast, 4'd0, irq_external, 3'd0, irq_timer, 3'd0, irq_software, 3'd0};
            m_req.valid = csr_valid;
            m_req.funct = csr_funct;
            m_req.addr = csr_addr;
            m_req.operand = csr_funct[2] ? {27'd0, csr_imm} : csr_rs1_data;
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            check_count++;
            if (csr_rd_valid !== exp_rd_valid) begin
                $display("ERR %0t: csr_rd_valid %b, expected %b", $time, csr_rd_valid,
                         exp_rd_valid);
                error_count++;
            end else if (exp_rd_valid && csr_rd_data !== exp_rd_data) begin
                $display("ERR %0t: csr_rd_data %h, expected %h", $time, csr_rd_data,
                         exp_rd_data);
                error_count++;
            end
            if (trap_taken !== exp_trap) begin
                $display("ERR %0t: trap_taken %b, expected %b", $time, trap_taken, exp_trap);
                error_count++;
            end else if (exp_trap && trap_pc !== exp_trap_pc) begin
                $display("ERR %0t: trap_pc %h, expected %h", $time, trap_pc, exp_trap_pc);
                error_count++;
            end
        end
    end

endmodule

/* verification/machine_csr_tb.sv */
`timescale 1ns/100ps
`include "csr_consts.svh"

module machine_csr_tb;

    localparam int TEST_CYCLES = 20 + 210 + 110 + 12 * 30 + 210;
    localparam int WATCHDOG_NS = TEST_CYCLES * 20 + 2000;

    logic                clk = 1'b0;
    logic                reset;
    logic                csr_valid;
    csr_pkg::csr_funct_t csr_funct;
    csr_pkg::csr_addr_t  csr_addr;
    csr_pkg::word_t      csr_rs1_data;
    logic [4:0]          csr_imm;
    logic                irq_external, irq_timer, irq_software;
    csr_pkg::irq_fast_t  irq_fast;
    csr_pkg::word_t      pc_value;
    logic                mret;
    logic                csr_rd_valid, trap_taken;
    csr_pkg::word_t      csr_rd_data, trap_pc;

    int             error_count, check_count;
    int             tb_fail = 0;
    int             prev_errors = 0;
    logic [31:0]    rng = 32'h2d4a_fccb;
    csr_pkg::csr_addr_t addr_list [13];
    csr_pkg::csr_addr_t rw_list [6];

    initial begin
        forever #10 clk = ~clk;
    end

    machine_csr_top machine_csr_top_inst (
        .clk(clk), .reset(reset), .csr_valid(csr_valid), .csr_funct(csr_funct),
        .csr_addr(csr_addr), .csr_rs1_data(csr_rs1_data), .csr_imm(csr_imm),
        .irq_external(irq_external), .irq_timer(irq_timer), .irq_software(irq_software),
        .irq_fast(irq_fast), .pc_value(pc_value), .mret(mret),
        .csr_rd_valid(csr_rd_valid), .csr_rd_data(csr_rd_data),
        .trap_taken(trap_taken), .trap_pc(trap_pc)
    );

    csr_checker csr_checker_inst (
        .clk(clk), .reset(reset), .csr_valid(csr_valid), .csr_funct(csr_funct),
        .csr_addr(csr_addr), .csr_rs1_data(csr_rs1_data), .csr_imm(csr_imm),
        .irq_external(irq_external), .irq_timer(irq_timer), .irq_software(irq_software),
        .irq_fast(irq_fast), .pc_value(pc_value), .mret(mret),
        .csr_rd_valid(csr_rd_valid), .csr_rd_data(csr_rd_data),
        .trap_taken(trap_taken), .trap_pc(trap_pc),
        .error_count(error_count), .check_count(check_count)
    );

    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // One clock of CSR port traffic with mret dropped unless set again
    task automatic issue(input logic v, input logic [2:0] f, input csr_pkg::csr_addr_t a,
                         input csr_pkg::word_t rs1, input logic [4:0] imm);
        @(posedge clk);
        csr_valid <= v;
        csr_funct <= f;
        csr_addr <= a;
        csr_rs1_data <= rs1;
        csr_imm <= imm;
        mret <= 1'b0;
    endtask

    task automatic drive_irqs(input logic [31:0] r);
        irq_external <= r[0];
        irq_timer <= r[1];
        irq_software <= r[2];
        irq_fast <= r[31:16];
    endtask

    task automatic report_test(input int num, input string name);
        int errs;
        repeat (3) issue(1'b0, 3'd0, 12'd0, 32'd0, 5'd0);
        @(negedge clk);
        errs = error_count + tb_fail - prev_errors;
        prev_errors = error_count + tb_fail;
        $display("test %0d %s: %s (%0d errors)", num, name, errs == 0 ? "ok" : "bad", errs);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the run did not finish in time");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [2:0]  f;
        logic        seen;
        int          wait_cycles;
        addr_list = '{`CSR_MSTATUS, `CSR_MISA, `CSR_MIE, `CSR_MTVEC, `CSR_MSCRATCH,
                      `CSR_MEPC, `CSR_MCAUSE, `CSR_MTVAL, `CSR_MIP, `CSR_MSTATUSH,
                      `CSR_MARCHID, `CSR_MIMPID, 12'h7C0};
        rw_list = '{`CSR_MSCRATCH, `CSR_MTVAL, `CSR_MEPC, `CSR_MTVEC, `CSR_MIE, `CSR_MSTATUS};
        reset = 1'b1;
        csr_valid = 1'b0;
        csr_funct = '0;
        csr_addr = '0;
        csr_rs1_data = '0;
        csr_imm = '0;
        {irq_external, irq_timer, irq_software} = 3'b000;
        irq_fast = '0;
        pc_value = '0;
        mret = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // Reads with csrrs and a zero operand
        foreach (addr_list[i]) issue(1'b1, 3'b010, addr_list[i], 32'd0, 5'd0);
        report_test(1, "reset values");

        for (int i = 0; i < 200; i++) begin
            r = xorshift32();
            f = {r[2], (r[1:0] == 2'b00) ? 2'b01 : r[1:0]};
            if (r[7:4] == 4'd0) begin
                // misa, marchid, mimpid or the unmapped address
                issue(1'b1, f, addr_list[(r[9:8] == 2'd0) ? 1 : 9 + r[9:8]], xorshift32(),
                      r[14:10]);
            end else begin
                issue(1'b1, f, rw_list[r[18:16] % 6], xorshift32(), r[14:10]);
            end
        end
        report_test(2, "random read-modify-write");

        issue(1'b1, 3'b111, `CSR_MSTATUS, 32'd0, 5'd8);    // Global enable off
        for (int i = 0; i < 100; i++) begin
            r = xorshift32();
            issue(r[3], 3'b010, `CSR_MIP, 32'd0, 5'd0);
            if (r[5:4] == 2'd0) drive_irqs(xorshift32());
        end
        drive_irqs(32'd0);
        report_test(3, "pending lines");

        issue(1'b1, 3'b001, `CSR_MIE, 32'hFFFF_FFFF, 5'd0);
        for (int n = 0; n < 12; n++) begin
            r = xorshift32();
            issue(1'b1, 3'b001, `CSR_MTVEC, {r[31:2], 1'b0, n[0]}, 5'd0);
            r = xorshift32() & {16'hFFFF, 13'd0, 3'b111};
            if (r == 32'd0) r[1] = 1'b1;
            drive_irqs(r);
            issue(1'b1, 3'b110, `CSR_MSTATUS, 32'd0, 5'd8);
            seen = 1'b0;
            wait_cycles = 0;
            while (!seen && wait_cycles < 12) begin
                issue(1'b0, 3'd0, 12'd0, 32'd0, 5'd0);
                pc_value <= xorshift32();
                @(negedge clk);
                seen = trap_taken;
                wait_cycles++;
            end
            if (!seen) begin
                $display("No trap was taken within 12 cycles of enabling interrupts");
                tb_fail++;
            end
            drive_irqs(32'd0);
            issue(1'b1, 3'b010, `CSR_MCAUSE, 32'd0, 5'd0);
            issue(1'b1, 3'b010, `CSR_MEPC, 32'd0, 5'd0);
            issue(1'b1, 3'b010, `CSR_MSTATUS, 32'd0, 5'd0);
        end
        report_test(4, "trap entry");

        issue(1'b1, 3'b001, `CSR_MTVEC, 32'h0000_8001, 5'd0);
        issue(1'b1, 3'b110, `CSR_MSTATUS, 32'd0, 5'd8);
        for (int i = 0; i < 200; i++) begin
            r = xorshift32();
            issue(r[0], r[1] ? 3'b001 : 3'b010, r[2] ? `CSR_MSCRATCH : `CSR_MSTATUS,
                  32'd0, 5'd0);
            mret <= (r[6:4] == 3'd0);
            pc_value <= xorshift32();
            if (r[9:8] == 2'd0) drive_irqs(xorshift32());
        end
        drive_irqs(32'd0);
        report_test(5, "mret and deferral");

        $display("tests 5, checks %0d, errors %0d", check_count, error_count + tb_fail);
        if (error_count + tb_fail == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
